// ==== bench/kmac_core_tb.sv ====
/*
  Testbench for the KMAC front end. Runs a table of strength, key length,
  stall and process timing cases against kmac_core, checks the key block
  against a byte level model and the message stream against the FIFO words.
*/

`default_nettype none

module kmac_core_tb;

  import sha3_pkg::*;
  import kmac_pkg::*;

  localparam int          NumRows    = 9;
  localparam int          TimeoutPad = 40;
  localparam logic [31:0] Seed       = 32'd3;
  // Key block zero extended to every index the controller can reach
  localparam int          PadW       = (2**KeyAddrW) * MsgWidth;

  typedef struct {
    string            name;
    keccak_strength_e strength;
    key_len_e         key_len;
    logic             kmac_en;
    logic             early;
    int               stall_pct;
    int               n_words;
  } row_t;

  // DUT ports
  logic                  clk_i;
  logic                  rst_ni;
  logic                  fifo_valid_i;
  logic [MsgWidth-1:0]   fifo_data_i;
  logic [MsgStrbW-1:0]   fifo_strb_i;
  logic                  fifo_ready_o;
  logic                  msg_valid_o;
  logic [MsgWidth-1:0]   msg_data_o;
  logic [MsgStrbW-1:0]   msg_strb_o;
  logic                  msg_ready_i;
  logic                  kmac_en_i;
  keccak_strength_e      strength_i;
  logic [MaxKeyLen-1:0]  key_data_i;
  key_len_e              key_len_i;
  logic                  start_i;
  logic                  process_i;
  logic                  done_i;
  logic                  escalate_i;
  logic                  process_o;
  logic                  fsm_error_o;

  // Values applied on the next falling edge
  logic                  fifo_valid_nx;
  logic [MsgWidth-1:0]   fifo_data_nx;
  logic [MsgStrbW-1:0]   fifo_strb_nx;
  logic                  kmac_en_nx;
  keccak_strength_e      strength_nx;
  logic [MaxKeyLen-1:0]  key_nx;
  key_len_e              key_len_nx;
  logic                  escalate_nx;
  // One-cycle pulse requests
  logic                  start_req;
  logic                  process_req;
  logic                  done_req;

  row_t        table_q [NumRows];
  logic [31:0] rng_state;
  int          errors;
  int          checks;
  int          cycle_cnt;
  int          timeout_limit;
  int          adv_count;
  int          proc_pulses;
  int          proc_cycle;

  kmac_core uut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fifo_valid_i (fifo_valid_i),
    .fifo_data_i  (fifo_data_i),
    .fifo_strb_i  (fifo_strb_i),
    .fifo_ready_o (fifo_ready_o),
    .msg_valid_o  (msg_valid_o),
    .msg_data_o   (msg_data_o),
    .msg_strb_o   (msg_strb_o),
    .msg_ready_i  (msg_ready_i),
    .kmac_en_i    (kmac_en_i),
    .strength_i   (strength_i),
    .key_data_i   (key_data_i),
    .key_len_i    (key_len_i),
    .start_i      (start_i),
    .process_i    (process_i),
    .done_i       (done_i),
    .escalate_i   (escalate_i),
    .process_o    (process_o),
    .fsm_error_o  (fsm_error_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Run length guard
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw(output logic [31:0] value);
    rng_state = xorshift32(rng_state);
    value     = rng_state;
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
    end
  endtask

  function automatic int key_length_bits(input key_len_e key_len);
    case (key_len)
      Key128:  return 128;
      Key192:  return 192;
      Key256:  return 256;
      Key384:  return 384;
      default: return 512;
    endcase
  endfunction

  // bytepad(encode_string(key), rate) laid out in bus byte order
  function automatic logic [PadW-1:0] encode_key_block(input keccak_strength_e strength,
                                                       input key_len_e key_len,
                                                       input logic [MaxKeyLen-1:0] key);
    logic [PadW-1:0] blk;
    int              len_bits;
    int              rate_bytes;
    int              pos;
    int              i;
    blk        = '0;
    len_bits   = key_length_bits(key_len);
    rate_bytes = int'(BlockLimit[strength]) * 8;
    // left_encode(rate)
    blk[7:0]   = 8'h01;
    blk[15:8]  = rate_bytes[7:0];
    // left_encode(key length) with the high byte first
    if (len_bits < 256) begin
      blk[23:16] = 8'h01;
      blk[31:24] = len_bits[7:0];
      pos        = 32;
    end else begin
      blk[23:16] = 8'h02;
      blk[31:24] = len_bits[15:8];
      blk[39:32] = len_bits[7:0];
      pos        = 40;
    end
    for (i = 0; i < len_bits; i++) begin
      blk[pos + i] = key[i];
    end
    return blk;
  endfunction

  // One clock cycle that drives on the falling edge, settles and then samples
  task automatic advance(input int stall_pct);
    logic [31:0] roll;
    @(negedge clk_i);
    draw(roll);
    start_i      = start_req;
    process_i    = process_req;
    done_i       = done_req;
    start_req    = 1'b0;
    process_req  = 1'b0;
    done_req     = 1'b0;
    kmac_en_i    = kmac_en_nx;
    strength_i   = strength_nx;
    key_data_i   = key_nx;
    key_len_i    = key_len_nx;
    escalate_i   = escalate_nx;
    fifo_valid_i = fifo_valid_nx;
    fifo_data_i  = fifo_data_nx;
    fifo_strb_i  = fifo_strb_nx;
    msg_ready_i  = ((roll % 100) >= stall_pct);
    adv_count++;
    #1;
    if (process_o) begin
      proc_pulses++;
      proc_cycle = adv_count;
    end
  endtask

  //////////////////////////////
  // One table row
  //////////////////////////////

  task automatic run_row(input row_t row);
    logic [PadW-1:0]     exp_blk;
    logic [MsgWidth-1:0] word_q[$];
    logic [MsgStrbW-1:0] strb_q[$];
    logic [MsgWidth-1:0] out_q[$];
    logic [MsgStrbW-1:0] out_strb_q[$];
    logic [31:0]         lo;
    logic [31:0]         hi;
    int                  limit;
    int                  key_count;
    int                  cycles;
    int                  sent;
    int                  msg_start;
    int                  i;

    // Fresh key and message for this row
    for (i = 0; i < MaxKeyLen / 32; i++) begin
      draw(lo);
      key_nx[i*32 +: 32] = lo;
    end
    for (i = 0; i < row.n_words; i++) begin
      draw(lo);
      draw(hi);
      word_q.push_back({hi, lo});
      strb_q.push_back(hi[11:4]);
    end
    exp_blk       = encode_key_block(row.strength, row.key_len, key_nx);
    limit         = row.kmac_en ? int'(BlockLimit[row.strength]) : 0;
    strength_nx   = row.strength;
    key_len_nx    = row.key_len;
    kmac_en_nx    = row.kmac_en;
    fifo_valid_nx = 1'b0;
    proc_pulses   = 0;

    start_req = 1'b1;
    advance(0);

    // FIFO offers its first word right away and must wait out the key block
    fifo_valid_nx = (row.n_words > 0);
    if (row.n_words > 0) begin
      fifo_data_nx = word_q[0];
      fifo_strb_nx = strb_q[0];
    end

    if (row.kmac_en) begin
      key_count = 0;
      cycles    = 0;
      while (key_count < limit) begin
        if (row.early && cycles == 1) begin
          process_req = 1'b1;
        end
        advance(row.stall_pct);
        check_value($sformatf("%s key valid", row.name), 1, msg_valid_o);
        check_value($sformatf("%s fifo held", row.name), 0, fifo_ready_o);
        // Offered word holds while the SHA3 core stalls
        check_value($sformatf("%s key word %0d", row.name, key_count),
                    exp_blk[key_count*MsgWidth +: MsgWidth], msg_data_o);
        check_value($sformatf("%s key strobe %0d", row.name, key_count), 8'hFF, msg_strb_o);
        if (msg_ready_i) begin
          key_count++;
        end
        cycles++;
      end
      // Index sits at the limit for one cycle with nothing offered
      advance(row.stall_pct);
      check_value($sformatf("%s key end valid", row.name), 0, msg_valid_o);
      check_value($sformatf("%s key end fifo held", row.name), 0, fifo_ready_o);
      check_value($sformatf("%s process in key phase", row.name), 0, proc_pulses);
    end
    msg_start = adv_count + 1;

    // Message words with the handshake seen from the FIFO side
    sent = 0;
    while (sent < row.n_words) begin
      fifo_data_nx = word_q[sent];
      fifo_strb_nx = strb_q[sent];
      advance(row.stall_pct);
      check_value($sformatf("%s msg valid", row.name), 1, msg_valid_o);
      check_value($sformatf("%s fifo ready", row.name), msg_ready_i, fifo_ready_o);
      if (msg_valid_o && msg_ready_i) begin
        out_q.push_back(msg_data_o);
        out_strb_q.push_back(msg_strb_o);
      end
      if (fifo_valid_i && fifo_ready_o) begin
        sent++;
      end
    end
    fifo_valid_nx = 1'b0;

    // Early request was latched while a late one goes out in its own cycle
    if (row.kmac_en && row.early) begin
      advance(0);
    end else begin
      process_req = 1'b1;
      advance(0);
      check_value($sformatf("%s process same cycle", row.name), 1, process_o);
    end
    done_req = row.kmac_en;
    advance(0);
    check_value($sformatf("%s process pulses", row.name), 1, proc_pulses);
    if (row.kmac_en && row.early) begin
      check_value($sformatf("%s early process cycle", row.name), msg_start, proc_cycle);
    end

    check_value($sformatf("%s word count", row.name), row.n_words, out_q.size());
    for (i = 0; i < row.n_words && i < out_q.size(); i++) begin
      check_value($sformatf("%s msg word %0d", row.name, i), word_q[i], out_q[i]);
      check_value($sformatf("%s msg strobe %0d", row.name, i), strb_q[i], out_strb_q[i]);
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin : stimulus
    int r;
    int i;

    rst_ni        = 1'b0;
    fifo_valid_i  = 1'b0;
    fifo_data_i   = '0;
    fifo_strb_i   = '0;
    msg_ready_i   = 1'b0;
    kmac_en_i     = 1'b0;
    strength_i    = L128;
    key_data_i    = '0;
    key_len_i     = Key128;
    start_i       = 1'b0;
    process_i     = 1'b0;
    done_i        = 1'b0;
    escalate_i    = 1'b0;
    fifo_valid_nx = 1'b0;
    fifo_data_nx  = '0;
    fifo_strb_nx  = '0;
    kmac_en_nx    = 1'b0;
    strength_nx   = L128;
    key_nx        = '0;
    key_len_nx    = Key128;
    escalate_nx   = 1'b0;
    start_req     = 1'b0;
    process_req   = 1'b0;
    done_req      = 1'b0;
    rng_state     = Seed;
    errors        = 0;
    checks        = 0;
    cycle_cnt     = 0;
    adv_count     = 0;
    proc_pulses   = 0;
    proc_cycle    = 0;

    // name, strength, key length, kmac_en, early, stall %, message words
    table_q[0] = '{"l128_k128_empty", L128, Key128, 1'b1, 1'b1, 0, 0};
    table_q[1] = '{"l224_k192_late", L224, Key192, 1'b1, 1'b0, 25, 4};
    table_q[2] = '{"l256_k256_early", L256, Key256, 1'b1, 1'b1, 30, 5};
    table_q[3] = '{"l384_k384_late", L384, Key384, 1'b1, 1'b0, 20, 3};
    table_q[4] = '{"l512_k512_early", L512, Key512, 1'b1, 1'b1, 40, 6};
    table_q[5] = '{"l512_k512_again", L512, Key512, 1'b1, 1'b0, 0, 2};
    table_q[6] = '{"l256_k128_late", L256, Key128, 1'b1, 1'b0, 35, 4};
    table_q[7] = '{"bypass", L128, Key512, 1'b0, 1'b0, 30, 5};
    table_q[8] = '{"l224_k384_early", L224, Key384, 1'b1, 1'b1, 10, 2};

    // Twice the words of each row plus a margin and one more for reset and escalation
    timeout_limit = TimeoutPad;
    for (r = 0; r < NumRows; r++) begin
      timeout_limit += 2 * table_q[r].n_words + TimeoutPad;
      if (table_q[r].kmac_en) begin
        timeout_limit += 2 * int'(BlockLimit[table_q[r].strength]);
      end
    end

    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;

    // Idle after reset
    advance(0);
    check_value("reset error flag", 0, fsm_error_o);
    check_value("reset process", 0, process_o);
    check_value("reset msg valid", 0, msg_valid_o);
    check_value("reset fifo ready", msg_ready_i, fifo_ready_o);

    for (r = 0; r < NumRows; r++) begin
      run_row(table_q[r]);
    end

    // Escalation from idle where the error must stay after the level drops
    kmac_en_nx  = 1'b1;
    escalate_nx = 1'b1;
    advance(0);
    escalate_nx = 1'b0;
    advance(0);
    check_value("escalate error set", 1, fsm_error_o);
    start_req = 1'b1;
    for (i = 0; i < 8; i++) begin
      advance(20);
      check_value("escalate error held", 1, fsm_error_o);
      check_value("escalate no key word", 0, msg_valid_o);
      check_value("escalate fifo path", msg_ready_i, fifo_ready_o);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the KMAC front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module kmac_core_tb \
  -f vlog.f \
  -o sim_kmac_core

./obj_dir/sim_kmac_core > sim.log 2>&1
cat sim.log

# The log decides the result
if grep -q "SOME TESTS FAILED" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi

echo "Simulation finished without failures"
exit 0

// ==== verilog/kmac_core.sv ====
/*
  KMAC front end between the message FIFO and the SHA3 core. Pushes the
  encoded key block after start when KMAC is enabled, then forwards the
  message; with KMAC off all traffic and process pass straight through.
*/

`default_nettype none

module kmac_core (
  input  logic                            clk_i,
  input  logic                            rst_ni,

  // Message FIFO
  input  logic                            fifo_valid_i,
  input  logic [sha3_pkg::MsgWidth-1:0]   fifo_data_i,
  input  logic [sha3_pkg::MsgStrbW-1:0]   fifo_strb_i,
  output logic                            fifo_ready_o,

  // SHA3 core message port
  output logic                            msg_valid_o,
  output logic [sha3_pkg::MsgWidth-1:0]   msg_data_o,
  output logic [sha3_pkg::MsgStrbW-1:0]   msg_strb_o,
  input  logic                            msg_ready_i,

  // Configuration
  input  logic                            kmac_en_i,
  input  sha3_pkg::keccak_strength_e      strength_i,
  input  logic [kmac_pkg::MaxKeyLen-1:0]  key_data_i,
  input  kmac_pkg::key_len_e              key_len_i,

  // Control pulses and escalation level
  input  logic                            start_i,
  input  logic                            process_i,
  input  logic                            done_i,
  input  logic                            escalate_i,

  output logic                            process_o,
  output logic                            fsm_error_o
);

  import sha3_pkg::*;

  // Controller to datapath
  logic                key_write;
  logic                key_valid;
  logic [KeyAddrW-1:0] key_index;

  //////////////////////////////
  // Controller
  //////////////////////////////

  kmac_ctrl_fsm u_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .kmac_en_i   (kmac_en_i),
    .start_i     (start_i),
    .process_i   (process_i),
    .done_i      (done_i),
    .escalate_i  (escalate_i),
    .strength_i  (strength_i),
    .msg_ready_i (msg_ready_i),
    .key_write_o (key_write),
    .key_valid_o (key_valid),
    .key_index_o (key_index),
    .process_o   (process_o),
    .fsm_error_o (fsm_error_o)
  );

  //////////////////////////////
  // Key datapath and mux
  //////////////////////////////

  kmac_key_datapath u_datapath (
    .key_data_i   (key_data_i),
    .key_len_i    (key_len_i),
    .strength_i   (strength_i),
    .key_write_i  (key_write),
    .key_valid_i  (key_valid),
    .key_index_i  (key_index),
    .fifo_valid_i (fifo_valid_i),
    .fifo_data_i  (fifo_data_i),
    .fifo_strb_i  (fifo_strb_i),
    .fifo_ready_o (fifo_ready_o),
    .msg_valid_o  (msg_valid_o),
    .msg_data_o   (msg_data_o),
    .msg_strb_o   (msg_strb_o),
    .msg_ready_i  (msg_ready_i)
  );

endmodule

`default_nettype wire

// ==== verilog/kmac_ctrl_fsm.sv ====
/*
  KMAC controller. Sequences idle, key block, message and flush, counts the
  key words against the rate of the selected strength and holds back an early
  process request until the key block has been sent. Escalation or a corrupt
  state register lands in a terminal error state that only reset leaves.
*/

`default_nettype none

module kmac_ctrl_fsm (
  input  logic                            clk_i,
  input  logic                            rst_ni,

  // Control
  input  logic                            kmac_en_i,
  input  logic                            start_i,
  input  logic                            process_i,
  input  logic                            done_i,
  input  logic                            escalate_i,
  input  sha3_pkg::keccak_strength_e      strength_i,

  // Back-pressure from the SHA3 core
  input  logic                            msg_ready_i,

  // To the key datapath
  output logic                            key_write_o,
  output logic                            key_valid_o,
  output logic [sha3_pkg::KeyAddrW-1:0]   key_index_o,

  // To the SHA3 core and status
  output logic                            process_o,
  output logic                            fsm_error_o
);

  import sha3_pkg::*;
  import kmac_pkg::*;

  kmac_st_e st_q, st_d;

  // Key word counter
  logic [KeyAddrW-1:0] key_index_q;
  logic                inc_index;
  logic                clr_index;

  // Rate of the selected strength in words
  logic [KeyAddrW-1:0] block_limit;
  logic                sent_block;

  // Process request generated by the controller
  logic kmac_process;
  logic process_latched_q;

  //////////////////////////////
  // Block limit
  //////////////////////////////

  always_comb begin
    case (strength_i)
      L128:    block_limit = BlockLimit[L128];
      L224:    block_limit = BlockLimit[L224];
      L256:    block_limit = BlockLimit[L256];
      L384:    block_limit = BlockLimit[L384];
      L512:    block_limit = BlockLimit[L512];
      // Unknown strength ends the key phase at once
      default: block_limit = '0;
    endcase
  end

  assign sent_block = (key_index_q == block_limit);

  //////////////////////////////
  // State machine
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_q <= StKmacIdle;
    end else begin
      st_q <= st_d;
    end
  end

  always_comb begin
    st_d         = st_q;
    key_write_o  = 1'b0;
    key_valid_o  = 1'b0;
    clr_index    = 1'b0;
    kmac_process = 1'b0;
    fsm_error_o  = 1'b0;

    case (st_q)
      StKmacIdle: begin
        if (kmac_en_i && start_i) begin
          st_d = StKey;
        end
      end

      // Full rate block goes out whatever process_i does
      StKey: begin
        key_write_o = 1'b1;
        if (sent_block) begin
          st_d      = StKmacMsg;
          clr_index = 1'b1;
        end else begin
          key_valid_o = 1'b1;
        end
      end

      // Message words pass through the datapath untouched
      StKmacMsg: begin
        if (process_i || process_latched_q) begin
          kmac_process = 1'b1;
          st_d         = StKmacFlush;
        end
      end

      StKmacFlush: begin
        if (done_i) begin
          st_d = StKmacIdle;
        end
      end

      StTerminalError: begin
        fsm_error_o = 1'b1;
      end

      // Illegal encoding, treat like escalation
      default: begin
        st_d        = StTerminalError;
        fsm_error_o = 1'b1;
      end
    endcase

    // Escalation wins over every transition
    if (escalate_i) begin
      st_d = StTerminalError;
    end
  end

  //////////////////////////////
  // Key word index
  //////////////////////////////

  // Advance only on a word taken by the SHA3 core
  assign inc_index = key_valid_o && msg_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_index_q <= '0;
    end else if (clr_index) begin
      key_index_q <= '0;
    end else if (inc_index) begin
      key_index_q <= key_index_q + 1'b1;
    end
  end

  assign key_index_o = key_index_q;

  //////////////////////////////
  // Process handling
  //////////////////////////////

  // Remember a process request that came while it could not be forwarded
  // e.g. an empty message where process_i arrives during the key block
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      process_latched_q <= 1'b0;
    end else if (process_i && !process_o) begin
      process_latched_q <= 1'b1;
    end else if (process_o || done_i) begin
      process_latched_q <= 1'b0;
    end
  end

  // Without KMAC the request goes straight to the SHA3 core
  assign process_o = kmac_en_i ? kmac_process : process_i;

endmodule

`default_nettype wire

// ==== verilog/kmac_key_datapath.sv ====
/*
  KMAC key datapath. Builds bytepad(encode_string(key), rate) as one wide
  block, slices out the word picked by the controller and multiplexes key
  words and FIFO words onto the SHA3 message stream.
*/

`default_nettype none

module kmac_key_datapath (
  // Key configuration
  input  logic [kmac_pkg::MaxKeyLen-1:0]  key_data_i,
  input  kmac_pkg::key_len_e              key_len_i,
  input  sha3_pkg::keccak_strength_e      strength_i,

  // From the controller
  input  logic                            key_write_i,
  input  logic                            key_valid_i,
  input  logic [sha3_pkg::KeyAddrW-1:0]   key_index_i,

  // Message FIFO side
  input  logic                            fifo_valid_i,
  input  logic [sha3_pkg::MsgWidth-1:0]   fifo_data_i,
  input  logic [sha3_pkg::MsgStrbW-1:0]   fifo_strb_i,
  output logic                            fifo_ready_o,

  // SHA3 core side
  output logic                            msg_valid_o,
  output logic [sha3_pkg::MsgWidth-1:0]   msg_data_o,
  output logic [sha3_pkg::MsgStrbW-1:0]   msg_strb_o,
  input  logic                            msg_ready_i
);

  import sha3_pkg::*;
  import kmac_pkg::*;

  // left_encode(rate)
  logic [PrefixW-1:0]     prefix;

  // prefix || left_encode(len) || key || zero fill
  logic [EncodedKeyW-1:0] encoded_block;

  // Block zero extended so that any index reads a defined word
  logic [(2**KeyAddrW)*MsgWidth-1:0] block_pad;

  logic [MsgWidth-1:0]    key_word;

  //////////////////////////////
  // Prefix select
  //////////////////////////////

  always_comb begin
    case (strength_i)
      L128:    prefix = BytepadPrefix[L128];
      L224:    prefix = BytepadPrefix[L224];
      L256:    prefix = BytepadPrefix[L256];
      L384:    prefix = BytepadPrefix[L384];
      L512:    prefix = BytepadPrefix[L512];
      default: prefix = '0;
    endcase
  end

  //////////////////////////////
  // Encoded key block
  //////////////////////////////

  // Length bytes are written in bus order, so the big-endian length of the
  // spec appears byte swapped here
  // Short keys need one length byte, 0x01 then the length in bits
  // Long keys need two, 0x02 then the length high byte first
  always_comb begin
    case (key_len_i)
      Key128: encoded_block = {{(MaxKeyLen - 120){1'b0}},
                               key_data_i[127:0], 16'h8001, prefix};
      Key192: encoded_block = {{(MaxKeyLen - 184){1'b0}},
                               key_data_i[191:0], 16'hC001, prefix};
      Key256: encoded_block = {{(MaxKeyLen - 256){1'b0}},
                               key_data_i[255:0], 24'h000102, prefix};
      Key384: encoded_block = {{(MaxKeyLen - 384){1'b0}},
                               key_data_i[383:0], 24'h800102, prefix};
      // Largest key fills the block exactly
      Key512: encoded_block = {key_data_i[511:0], 24'h000202, prefix};
      default: encoded_block = '0;
    endcase
  end

  // Words past the encoded block read as zero, the rest of the rate
  assign block_pad = {{((2**KeyAddrW)*MsgWidth - EncodedKeyW){1'b0}}, encoded_block};

  // Word slicer
  assign key_word = block_pad[key_index_i*MsgWidth +: MsgWidth];

  //////////////////////////////
  // Stream multiplexer
  //////////////////////////////

  // Key phase owns the bus and stalls the FIFO
  assign msg_valid_o  = key_write_i ? key_valid_i : fifo_valid_i;
  assign msg_data_o   = key_write_i ? key_word    : fifo_data_i;

  // Key words are always full width
  assign msg_strb_o   = key_write_i ? '1          : fifo_strb_i;
  assign fifo_ready_o = key_write_i ? 1'b0        : msg_ready_i;

endmodule

`default_nettype wire

// ==== verilog/kmac_pkg.sv ====
/*
  KMAC side definitions: key length encoding, encoded key block width and the
  sparse controller state encoding. Used by the controller, the key datapath,
  the top level and the testbench.
*/

`default_nettype none

package kmac_pkg;

  //////////////////////////////
  // Key block geometry
  //////////////////////////////

  // Widest supported secret key
  localparam int MaxKeyLen = 512;

  // left_encode(len(key)) takes at most three bytes
  localparam int KeyLenEncW = 24;

  // left_encode(rate) in front of the key string
  localparam int PrefixW = 16;

  // Full block as pushed to the SHA3 core, 552 bits
  localparam int EncodedKeyW = MaxKeyLen + KeyLenEncW + PrefixW;

  // Secret key length select
  typedef enum logic [2:0] {
    Key128 = 3'd0,
    Key192 = 3'd1,
    Key256 = 3'd2,
    Key384 = 3'd3,
    Key512 = 3'd4
  } key_len_e;

  //////////////////////////////
  // Controller states
  //////////////////////////////

  localparam int StateW = 6;

  // Sparse encoding, every pair of states is at least 3 bits apart
  // A single flipped bit never lands on another legal state
  typedef enum logic [StateW-1:0] {
    StKmacIdle      = 6'b011000,
    // Pushing the encoded key block
    StKey           = 6'b010111,
    // Forwarding the message stream
    StKmacMsg       = 6'b001110,
    // Waiting for the SHA3 core to finish
    StKmacFlush     = 6'b101011,
    StTerminalError = 6'b100000
  } kmac_st_e;

endpackage

`default_nettype wire

// ==== verilog/sha3_pkg.sv ====
/*
  Keccak side definitions shared by the KMAC front end and its testbench.
  Holds the message word geometry, the strength encoding and the per-strength
  rate and bytepad prefix tables.
*/

`default_nettype none

package sha3_pkg;

  //////////////////////////////
  // Message geometry
  //////////////////////////////

  // One message word towards the SHA3 core
  localparam int MsgWidth = 64;

  // One strobe bit per message byte
  localparam int MsgStrbW = MsgWidth / 8;

  // Key word index, wide enough for the largest rate in words
  localparam int KeyAddrW = 5;

  // Number of supported strengths
  localparam int NumStrength = 5;

  //////////////////////////////
  // Strength
  //////////////////////////////

  // Security strength, selects the Keccak rate
  typedef enum logic [2:0] {
    L128 = 3'd0,
    L224 = 3'd1,
    L256 = 3'd2,
    L384 = 3'd3,
    L512 = 3'd4
  } keccak_strength_e;

  // Rate in 64-bit words, indexed by strength
  // 168, 144, 136, 104 and 72 bytes
  localparam logic [KeyAddrW-1:0] BlockLimit [NumStrength] = '{
    5'd21, 5'd18, 5'd17, 5'd13, 5'd9
  };

  // left_encode(rate) as sent on the bus, little-endian
  // Low byte is the length byte 0x01, high byte is the rate in bytes
  localparam logic [15:0] BytepadPrefix [NumStrength] = '{
    16'hA801, 16'h9001, 16'h8801, 16'h6801, 16'h4801
  };

endpackage

`default_nettype wire

// ==== vlog.f ====
verilog/sha3_pkg.sv
verilog/kmac_pkg.sv
verilog/kmac_ctrl_fsm.sv
verilog/kmac_key_datapath.sv
verilog/kmac_core.sv
bench/kmac_core_tb.sv
